/* sm83_ctrl_pkg.sv */
package sm83_ctrl_pkg;

  localparam int MCYCLE_W = 3;
  localparam int OPCODE_W = 8;

  // M-cycle numbers as seen by the step generators
  localparam logic [MCYCLE_W-1:0] MC_0 = 3'd0;
  localparam logic [MCYCLE_W-1:0] MC_1 = 3'd1;
  localparam logic [MCYCLE_W-1:0] MC_2 = 3'd2;

  // Instruction lengths in M-cycles
  localparam logic [MCYCLE_W-1:0] CYC_1 = 3'd1;
  localparam logic [MCYCLE_W-1:0] CYC_2 = 3'd2;
  localparam logic [MCYCLE_W-1:0] CYC_3 = 3'd3;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    IF    = 2'd1,
    READ  = 2'd2,
    WRITE = 2'd3
  } bus_op_t;

  // Codes 0 to 7 follow the opcode register field, 6 is the [HL] slot
  typedef enum logic [3:0] {
    B = 4'd0,
    C = 4'd1,
    D = 4'd2,
    E = 4'd3,
    H = 4'd4,
    L = 4'd5,
    A = 4'd7,
    Z = 4'd8,
    W = 4'd9
  } reg8_t;

  typedef enum logic [2:0] {
    BC = 3'd0,
    DE = 3'd1,
    HL = 3'd2,
    SP = 3'd3,
    PC = 3'd4,
    WZ = 3'd5
  } reg16_t;

  typedef enum logic [4:0] {
    ADD  = 5'd0,
    ADC  = 5'd1,
    SUB  = 5'd2,
    SBC  = 5'd3,
    AND  = 5'd4,
    XOR  = 5'd5,
    OR   = 5'd6,
    CP   = 5'd7,
    RLCA = 5'd16,
    RRCA = 5'd17,
    RLA  = 5'd18,
    RRA  = 5'd19,
    DAA  = 5'd20,
    CPL  = 5'd21,
    SCF  = 5'd22,
    CCF  = 5'd23
  } alu_op_t;

  typedef enum logic {
    ALU_A_REG = 1'b0,
    ALU_A_ACC = 1'b1
  } alu_src_a_t;

  typedef enum logic [1:0] {
    ALU_B_ONE  = 2'd0,
    ALU_B_ZERO = 2'd1,
    ALU_B_REG  = 2'd2
  } alu_src_b_t;

  typedef enum logic {
    DOUT_ALU = 1'b0,
    DOUT_RF  = 1'b1
  } dout_sel_t;

  typedef struct packed {
    logic z;
    logic n;
    logic h;
    logic c;
  } flags_t;

  typedef enum logic [3:0] {
    C_NOP       = 4'd0,
    C_LD_RR_D16 = 4'd1,
    C_ST_IND    = 4'd2,
    C_LD_IND    = 4'd3,
    C_LD_R_D8   = 4'd4,
    C_INCDEC_RR = 4'd5,
    C_INCDEC_R  = 4'd6,
    C_LD_R_R    = 4'd7,
    C_LD_R_HL   = 4'd8,
    C_LD_HL_R   = 4'd9,
    C_ALU       = 4'd10,
    C_ALU_D8    = 4'd11,
    C_ACC       = 4'd12
  } insn_class_t;

  typedef struct packed {
    insn_class_t         cls;
    reg8_t               r_dst;
    reg8_t               r_src;
    reg16_t              rr;
    alu_op_t             alu_op;
    logic                idu_dec;
    logic                hl_mem;
    logic [MCYCLE_W-1:0] n_cycles;
  } insn_t;

  typedef struct packed {
    bus_op_t bus_op;
    logic    idu_en;
    logic    idu_dec;
    logic    rr_read;
    reg16_t  rr_read_sel;
    logic    rr_write;
    reg16_t  rr_write_sel;
    logic    wz_copy;
    reg16_t  wz_copy_sel;
  } addr_ctrl_t;

  typedef struct packed {
    logic       r_read;
    reg8_t      r_read_sel;
    logic       r_write;
    reg8_t      r_write_sel;
    logic       alu_en;
    alu_op_t    alu_op;
    alu_src_a_t alu_src_a;
    alu_src_b_t alu_src_b;
    logic       flags_we;
    flags_t     flag_mask_n;
    dout_sel_t  dout_sel;
  } data_ctrl_t;

  // Plain fetch cycle, PC steps through the IDU
  localparam addr_ctrl_t ADDR_CTRL_DEFAULT = '{
    bus_op:       IF,
    idu_en:       1'b1,
    idu_dec:      1'b0,
    rr_read:      1'b1,
    rr_read_sel:  PC,
    rr_write:     1'b1,
    rr_write_sel: PC,
    wz_copy:      1'b0,
    wz_copy_sel:  BC
  };

  localparam data_ctrl_t DATA_CTRL_DEFAULT = '{
    r_read:      1'b0,
    r_read_sel:  A,
    r_write:     1'b0,
    r_write_sel: A,
    alu_en:      1'b0,
    alu_op:      ADD,
    alu_src_a:   ALU_A_REG,
    alu_src_b:   ALU_B_ONE,
    flags_we:    1'b0,
    flag_mask_n: '0,
    dout_sel:    DOUT_ALU
  };

endpackage

/* insn_sequencer.sv */
`timescale 1ns/1ps

module insn_sequencer (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [sm83_ctrl_pkg::OPCODE_W-1:0] next_opcode,
  input  logic [sm83_ctrl_pkg::MCYCLE_W-1:0] n_cycles,
  output logic [sm83_ctrl_pkg::OPCODE_W-1:0] cur_opcode,
  output logic [sm83_ctrl_pkg::MCYCLE_W-1:0] m_cycle
);

  logic [sm83_ctrl_pkg::OPCODE_W-1:0] opcode_q;
  logic                               last_cycle;

  // A new opcode is live on the input during M-cycle 0
  assign cur_opcode = (m_cycle == sm83_ctrl_pkg::MC_0) ? next_opcode : opcode_q;
  assign last_cycle = (m_cycle == n_cycles - sm83_ctrl_pkg::MC_1);

  always_ff @(posedge clk) begin
    if (m_cycle == sm83_ctrl_pkg::MC_0) begin
      opcode_q <= next_opcode;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_cycle <= sm83_ctrl_pkg::MC_0;
    end else if (last_cycle) begin
      m_cycle <= sm83_ctrl_pkg::MC_0;
    end else begin
      m_cycle <= m_cycle + sm83_ctrl_pkg::MC_1;
    end
  end

endmodule

/* insn_decoder.sv */
`timescale 1ns/1ps

module insn_decoder (
  input  logic [sm83_ctrl_pkg::OPCODE_W-1:0] cur_opcode,
  output sm83_ctrl_pkg::insn_t               insn
);

  logic [2:0] f_dst;
  logic [2:0] f_src;
  logic       dst_hl;
  logic       src_hl;

  assign f_dst  = cur_opcode[5:3];
  assign f_src  = cur_opcode[2:0];
  assign dst_hl = (f_dst == 3'b110);
  assign src_hl = (f_src == 3'b110);

  always_comb begin
    insn.cls      = sm83_ctrl_pkg::C_NOP;
    insn.r_dst    = sm83_ctrl_pkg::reg8_t'({1'b0, f_dst});
    insn.r_src    = sm83_ctrl_pkg::reg8_t'({1'b0, f_src});
    insn.rr       = sm83_ctrl_pkg::reg16_t'({1'b0, cur_opcode[5:4]});
    insn.alu_op   = sm83_ctrl_pkg::alu_op_t'({2'b00, f_dst});
    insn.idu_dec  = 1'b0;
    insn.hl_mem   = 1'b0;
    insn.n_cycles = sm83_ctrl_pkg::CYC_1;

    case (cur_opcode[7:6])
      2'b00: begin
        if (cur_opcode[3:0] == 4'b0001) begin
          insn.cls      = sm83_ctrl_pkg::C_LD_RR_D16;
          insn.n_cycles = sm83_ctrl_pkg::CYC_3;
        end else begin
          case (f_src)
            3'b010: begin
              // Bit 5 picks HL+/- over BC/DE, bit 3 picks load over store
              insn.cls      = cur_opcode[3] ? sm83_ctrl_pkg::C_LD_IND
                                            : sm83_ctrl_pkg::C_ST_IND;
              insn.r_dst    = sm83_ctrl_pkg::A;
              insn.r_src    = sm83_ctrl_pkg::A;
              insn.rr       = cur_opcode[5] ? sm83_ctrl_pkg::HL
                                            : sm83_ctrl_pkg::reg16_t'({2'b00, cur_opcode[4]});
              insn.idu_dec  = cur_opcode[4];
              insn.n_cycles = sm83_ctrl_pkg::CYC_2;
            end
            3'b011: begin
              insn.cls      = sm83_ctrl_pkg::C_INCDEC_RR;
              insn.idu_dec  = cur_opcode[3];
              insn.n_cycles = sm83_ctrl_pkg::CYC_2;
            end
            3'b100, 3'b101: begin
              insn.cls      = sm83_ctrl_pkg::C_INCDEC_R;
              insn.r_src    = insn.r_dst;
              insn.alu_op   = cur_opcode[0] ? sm83_ctrl_pkg::SUB : sm83_ctrl_pkg::ADD;
              insn.hl_mem   = dst_hl;
              insn.n_cycles = dst_hl ? sm83_ctrl_pkg::CYC_3 : sm83_ctrl_pkg::CYC_1;
            end
            3'b110: begin
              insn.cls      = sm83_ctrl_pkg::C_LD_R_D8;
              insn.hl_mem   = dst_hl;
              insn.n_cycles = dst_hl ? sm83_ctrl_pkg::CYC_3 : sm83_ctrl_pkg::CYC_2;
            end
            3'b111: begin
              insn.cls    = sm83_ctrl_pkg::C_ACC;
              insn.alu_op = sm83_ctrl_pkg::alu_op_t'({2'b10, f_dst});
            end
            // NOP, jumps and ADD HL,rr stay NOPs here
            default: begin
            end
          endcase
        end
      end
      2'b01: begin
        // [HL],[HL] is HALT and stays a NOP here
        if (src_hl && !dst_hl) begin
          insn.cls      = sm83_ctrl_pkg::C_LD_R_HL;
          insn.hl_mem   = 1'b1;
          insn.n_cycles = sm83_ctrl_pkg::CYC_2;
        end else if (dst_hl && !src_hl) begin
          insn.cls      = sm83_ctrl_pkg::C_LD_HL_R;
          insn.hl_mem   = 1'b1;
          insn.n_cycles = sm83_ctrl_pkg::CYC_2;
        end else if (!dst_hl) begin
          insn.cls = sm83_ctrl_pkg::C_LD_R_R;
        end
      end
      2'b10: begin
        insn.cls      = sm83_ctrl_pkg::C_ALU;
        insn.hl_mem   = src_hl;
        insn.n_cycles = src_hl ? sm83_ctrl_pkg::CYC_2 : sm83_ctrl_pkg::CYC_1;
      end
      default: begin
        if (src_hl) begin
          insn.cls      = sm83_ctrl_pkg::C_ALU_D8;
          insn.n_cycles = sm83_ctrl_pkg::CYC_2;
        end
      end
    endcase
  end

endmodule

/* addr_step_gen.sv */
`timescale 1ns/1ps

module addr_step_gen (
  input  sm83_ctrl_pkg::insn_t               insn,
  input  logic [sm83_ctrl_pkg::MCYCLE_W-1:0] m_cycle,
  output sm83_ctrl_pkg::addr_ctrl_t          addr_ctrl
);

  // Bus cycle addressed by a pair, PC holds still
  function automatic sm83_ctrl_pkg::addr_ctrl_t pair_access(
    input sm83_ctrl_pkg::bus_op_t op,
    input sm83_ctrl_pkg::reg16_t  rr
  );
    sm83_ctrl_pkg::addr_ctrl_t ac;
    ac             = sm83_ctrl_pkg::ADDR_CTRL_DEFAULT;
    ac.bus_op      = op;
    ac.idu_en      = 1'b0;
    ac.rr_read     = 1'b1;
    ac.rr_read_sel = rr;
    ac.rr_write    = 1'b0;
    return ac;
  endfunction

  logic first_cycle;
  logic second_cycle;

  assign first_cycle  = (m_cycle == sm83_ctrl_pkg::MC_0);
  assign second_cycle = (m_cycle == sm83_ctrl_pkg::MC_1);

  always_comb begin
    addr_ctrl = sm83_ctrl_pkg::ADDR_CTRL_DEFAULT;

    case (insn.cls)
      sm83_ctrl_pkg::C_LD_RR_D16: begin
        if (m_cycle == sm83_ctrl_pkg::MC_2) begin
          addr_ctrl.wz_copy     = 1'b1;
          addr_ctrl.wz_copy_sel = insn.rr;
        end else begin
          addr_ctrl.bus_op = sm83_ctrl_pkg::READ;
        end
      end
      sm83_ctrl_pkg::C_ST_IND, sm83_ctrl_pkg::C_LD_IND: begin
        if (first_cycle) begin
          addr_ctrl = pair_access(insn.cls == sm83_ctrl_pkg::C_ST_IND ? sm83_ctrl_pkg::WRITE
                                                                      : sm83_ctrl_pkg::READ,
                                  insn.rr);
          // HL+/- steps the pair while the bus still sees the old address
          if (insn.rr == sm83_ctrl_pkg::HL) begin
            addr_ctrl.idu_en       = 1'b1;
            addr_ctrl.idu_dec      = insn.idu_dec;
            addr_ctrl.rr_write     = 1'b1;
            addr_ctrl.rr_write_sel = sm83_ctrl_pkg::HL;
          end
        end
      end
      sm83_ctrl_pkg::C_INCDEC_RR: begin
        if (first_cycle) begin
          addr_ctrl.bus_op       = sm83_ctrl_pkg::IDLE;
          addr_ctrl.idu_dec      = insn.idu_dec;
          addr_ctrl.rr_read_sel  = insn.rr;
          addr_ctrl.rr_write_sel = insn.rr;
        end
      end
      sm83_ctrl_pkg::C_LD_R_D8: begin
        if (first_cycle) begin
          addr_ctrl.bus_op = sm83_ctrl_pkg::READ;
        end else if (insn.hl_mem && second_cycle) begin
          addr_ctrl = pair_access(sm83_ctrl_pkg::WRITE, sm83_ctrl_pkg::HL);
        end
      end
      sm83_ctrl_pkg::C_ALU_D8: begin
        if (first_cycle) begin
          addr_ctrl.bus_op = sm83_ctrl_pkg::READ;
        end
      end
      sm83_ctrl_pkg::C_INCDEC_R: begin
        // Read-modify-write on [HL]
        if (insn.hl_mem && first_cycle) begin
          addr_ctrl = pair_access(sm83_ctrl_pkg::READ, sm83_ctrl_pkg::HL);
        end else if (insn.hl_mem && second_cycle) begin
          addr_ctrl = pair_access(sm83_ctrl_pkg::WRITE, sm83_ctrl_pkg::HL);
        end
      end
      sm83_ctrl_pkg::C_LD_R_HL, sm83_ctrl_pkg::C_ALU: begin
        if (insn.hl_mem && first_cycle) begin
          addr_ctrl = pair_access(sm83_ctrl_pkg::READ, sm83_ctrl_pkg::HL);
        end
      end
      sm83_ctrl_pkg::C_LD_HL_R: begin
        if (first_cycle) begin
          addr_ctrl = pair_access(sm83_ctrl_pkg::WRITE, sm83_ctrl_pkg::HL);
        end
      end
      default: begin
      end
    endcase
  end

endmodule

/* data_step_gen.sv */
`timescale 1ns/1ps

module data_step_gen (
  input  sm83_ctrl_pkg::insn_t               insn,
  input  logic [sm83_ctrl_pkg::MCYCLE_W-1:0] m_cycle,
  output sm83_ctrl_pkg::data_ctrl_t          data_ctrl
);

  // Byte from the bus lands in a temp register
  function automatic sm83_ctrl_pkg::data_ctrl_t bus_to(input sm83_ctrl_pkg::reg8_t dst);
    sm83_ctrl_pkg::data_ctrl_t dc;
    dc             = sm83_ctrl_pkg::DATA_CTRL_DEFAULT;
    dc.r_write     = 1'b1;
    dc.r_write_sel = dst;
    return dc;
  endfunction

  // Register move as src + 0, flags untouched
  function automatic sm83_ctrl_pkg::data_ctrl_t move_byte(
    input sm83_ctrl_pkg::reg8_t dst,
    input sm83_ctrl_pkg::reg8_t src
  );
    sm83_ctrl_pkg::data_ctrl_t dc;
    dc             = sm83_ctrl_pkg::DATA_CTRL_DEFAULT;
    dc.r_read      = 1'b1;
    dc.r_read_sel  = src;
    dc.r_write     = 1'b1;
    dc.r_write_sel = dst;
    dc.alu_en      = 1'b1;
    dc.alu_src_b   = sm83_ctrl_pkg::ALU_B_ZERO;
    return dc;
  endfunction

  // A op src, CP only sets flags
  function automatic sm83_ctrl_pkg::data_ctrl_t acc_op(
    input sm83_ctrl_pkg::reg8_t   src,
    input sm83_ctrl_pkg::alu_op_t op
  );
    sm83_ctrl_pkg::data_ctrl_t dc;
    dc            = sm83_ctrl_pkg::DATA_CTRL_DEFAULT;
    dc.r_read     = 1'b1;
    dc.r_read_sel = src;
    dc.r_write    = (op != sm83_ctrl_pkg::CP);
    dc.alu_en     = 1'b1;
    dc.alu_op     = op;
    dc.alu_src_a  = sm83_ctrl_pkg::ALU_A_ACC;
    dc.alu_src_b  = sm83_ctrl_pkg::ALU_B_REG;
    dc.flags_we   = 1'b1;
    return dc;
  endfunction

  // INC/DEC by one, carry kept
  function automatic sm83_ctrl_pkg::data_ctrl_t step_byte(
    input sm83_ctrl_pkg::reg8_t   r,
    input sm83_ctrl_pkg::alu_op_t op
  );
    sm83_ctrl_pkg::data_ctrl_t dc;
    dc               = sm83_ctrl_pkg::DATA_CTRL_DEFAULT;
    dc.r_read        = 1'b1;
    dc.r_read_sel    = r;
    dc.r_write       = 1'b1;
    dc.r_write_sel   = r;
    dc.alu_en        = 1'b1;
    dc.alu_op        = op;
    dc.flags_we      = 1'b1;
    dc.flag_mask_n.c = 1'b1;
    return dc;
  endfunction

  logic first_cycle;
  logic second_cycle;
  logic acc_touch;

  assign first_cycle  = (m_cycle == sm83_ctrl_pkg::MC_0);
  assign second_cycle = (m_cycle == sm83_ctrl_pkg::MC_1);
  // SCF and CCF work on flags only
  assign acc_touch    = (insn.alu_op != sm83_ctrl_pkg::SCF) &&
                        (insn.alu_op != sm83_ctrl_pkg::CCF);

  always_comb begin
    data_ctrl = sm83_ctrl_pkg::DATA_CTRL_DEFAULT;

    case (insn.cls)
      sm83_ctrl_pkg::C_LD_RR_D16: begin
        if (first_cycle) begin
          data_ctrl = bus_to(sm83_ctrl_pkg::Z);
        end else if (second_cycle) begin
          data_ctrl = bus_to(sm83_ctrl_pkg::W);
        end
      end
      sm83_ctrl_pkg::C_ST_IND, sm83_ctrl_pkg::C_LD_HL_R: begin
        if (first_cycle) begin
          data_ctrl.r_read     = 1'b1;
          data_ctrl.r_read_sel = insn.r_src;
          data_ctrl.dout_sel   = sm83_ctrl_pkg::DOUT_RF;
        end
      end
      sm83_ctrl_pkg::C_LD_IND, sm83_ctrl_pkg::C_LD_R_HL: begin
        if (first_cycle) begin
          data_ctrl = bus_to(sm83_ctrl_pkg::Z);
        end else begin
          data_ctrl = move_byte(insn.r_dst, sm83_ctrl_pkg::Z);
        end
      end
      sm83_ctrl_pkg::C_LD_R_D8: begin
        if (first_cycle) begin
          data_ctrl = bus_to(sm83_ctrl_pkg::Z);
        end else if (second_cycle) begin
          data_ctrl = move_byte(insn.r_dst, sm83_ctrl_pkg::Z);
          // LD [HL],d8 sends Z through the ALU to the bus instead
          if (insn.hl_mem) begin
            data_ctrl.r_write     = 1'b0;
            data_ctrl.r_write_sel = sm83_ctrl_pkg::A;
          end
        end
      end
      sm83_ctrl_pkg::C_INCDEC_R: begin
        if (!insn.hl_mem) begin
          data_ctrl = step_byte(insn.r_dst, insn.alu_op);
        end else if (first_cycle) begin
          data_ctrl = bus_to(sm83_ctrl_pkg::Z);
        end else if (second_cycle) begin
          data_ctrl         = step_byte(sm83_ctrl_pkg::Z, insn.alu_op);
          data_ctrl.r_write = 1'b0;
        end
      end
      sm83_ctrl_pkg::C_LD_R_R: begin
        data_ctrl = move_byte(insn.r_dst, insn.r_src);
      end
      sm83_ctrl_pkg::C_ALU, sm83_ctrl_pkg::C_ALU_D8: begin
        if (insn.cls == sm83_ctrl_pkg::C_ALU && !insn.hl_mem) begin
          data_ctrl = acc_op(insn.r_src, insn.alu_op);
        end else if (first_cycle) begin
          data_ctrl = bus_to(sm83_ctrl_pkg::Z);
        end else begin
          data_ctrl = acc_op(sm83_ctrl_pkg::Z, insn.alu_op);
        end
      end
      sm83_ctrl_pkg::C_ACC: begin
        data_ctrl.alu_en   = 1'b1;
        data_ctrl.alu_op   = insn.alu_op;
        data_ctrl.r_read   = acc_touch;
        data_ctrl.r_write  = acc_touch;
        data_ctrl.flags_we = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

/* sm83_control.sv */
`timescale 1ns/1ps

module sm83_control (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [sm83_ctrl_pkg::OPCODE_W-1:0] next_opcode,
  output sm83_ctrl_pkg::addr_ctrl_t          addr_ctrl,
  output sm83_ctrl_pkg::data_ctrl_t          data_ctrl
);

  logic [sm83_ctrl_pkg::OPCODE_W-1:0] cur_opcode;
  logic [sm83_ctrl_pkg::MCYCLE_W-1:0] m_cycle;
  sm83_ctrl_pkg::insn_t               insn;

  insn_sequencer i_sequencer (
    .clk         (clk),
    .rst         (rst),
    .next_opcode (next_opcode),
    .n_cycles    (insn.n_cycles),
    .cur_opcode  (cur_opcode),
    .m_cycle     (m_cycle)
  );

  insn_decoder i_decoder (
    .cur_opcode (cur_opcode),
    .insn       (insn)
  );

  // Address and data halves of the control word
  addr_step_gen i_addr_step (
    .insn      (insn),
    .m_cycle   (m_cycle),
    .addr_ctrl (addr_ctrl)
  );

  data_step_gen i_data_step (
    .insn      (insn),
    .m_cycle   (m_cycle),
    .data_ctrl (data_ctrl)
  );

endmodule

/* tb_sm83_control.sv */
`timescale 1ns/1ps

module tb_sm83_control;

  localparam int MAX_LINES      = 64;
  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_MARGIN = 20;

  // One golden line, laid out as the hex columns of the data file
  typedef struct packed {
    logic [7:0]                test_num;
    logic [3:0]                rst_val;
    logic [7:0]                opcode;
    sm83_ctrl_pkg::addr_ctrl_t addr_exp;
    logic [2:0]                data_pad;
    sm83_ctrl_pkg::data_ctrl_t data_exp;
  } golden_line_t;

  logic                               clk;
  logic                               rst;
  logic [sm83_ctrl_pkg::OPCODE_W-1:0] next_opcode;
  sm83_ctrl_pkg::addr_ctrl_t          addr_ctrl;
  sm83_ctrl_pkg::data_ctrl_t          data_ctrl;

  logic [$bits(golden_line_t)-1:0] golden_mem [MAX_LINES];

  int line_count;
  int cycle_count;
  int cycle_limit;
  int error_count;
  int test_errors;
  int tests_ok;
  int tests_bad;

  sm83_control i_dut (
    .clk         (clk),
    .rst         (rst),
    .next_opcode (next_opcode),
    .addr_ctrl   (addr_ctrl),
    .data_ctrl   (data_ctrl)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic string test_title(input logic [7:0] num);
    case (num)
      8'd1:    return "single-cycle group";
      8'd2:    return "LD rr,d16";
      8'd3:    return "indirect loads";
      8'd4:    return "[HL] operands";
      8'd5:    return "INC [HL] and DEC BC";
      8'd6:    return "unlisted opcode and reset";
      default: return "unnamed";
    endcase
  endfunction

  task automatic check_addr(input int line_no, input sm83_ctrl_pkg::addr_ctrl_t expected,
                            input sm83_ctrl_pkg::addr_ctrl_t actual);
    if (actual !== expected) begin
      $display("FAILED line %0d: addr_ctrl expected %h, got %h", line_no, expected, actual);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_data(input int line_no, input sm83_ctrl_pkg::data_ctrl_t expected,
                            input sm83_ctrl_pkg::data_ctrl_t actual);
    if (actual !== expected) begin
      $display("FAILED line %0d: data_ctrl expected %h, got %h", line_no, expected, actual);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic close_test(input logic [7:0] num);
    if (test_errors == 0) begin
      $display("test %0d (%s): ok", num, test_title(num));
      tests_ok++;
    end else begin
      $display("test %0d (%s): %0d mismatches", num, test_title(num), test_errors);
      tests_bad++;
    end
    test_errors = 0;
  endtask

  initial begin
    golden_line_t cur;
    golden_line_t nxt;
    golden_line_t probe;
    rst         = 1'b1;
    next_opcode = '0;
    error_count = 0;
    test_errors = 0;
    tests_ok    = 0;
    tests_bad   = 0;

    // Unused entries keep the all-ones end marker
    for (int i = 0; i < MAX_LINES; i++) begin
      golden_mem[i] = '1;
    end
    $readmemh("sm83_control_golden.txt", golden_mem);
    line_count = MAX_LINES;
    for (int i = MAX_LINES - 1; i >= 0; i--) begin
      probe = golden_line_t'(golden_mem[i]);
      if (probe.test_num == 8'hff) begin
        line_count = i;
      end
    end
    cycle_limit = line_count + RESET_CYCLES + TIMEOUT_MARGIN;
    if (line_count == 0) begin
      $display("golden file sm83_control_golden.txt is missing or holds no lines");
      error_count++;
    end

    repeat (RESET_CYCLES) @(posedge clk);

    for (int i = 0; i < line_count; i++) begin
      cur = golden_line_t'(golden_mem[i]);
      #1;
      rst         = cur.rst_val[0];
      next_opcode = cur.opcode;
      // Outputs are combinational, settled well before the next edge
      #2;
      check_addr(i, cur.addr_exp, addr_ctrl);
      check_data(i, cur.data_exp, data_ctrl);
      if (i + 1 < line_count) begin
        nxt = golden_line_t'(golden_mem[i + 1]);
      end else begin
        nxt = '1;
      end
      if (nxt.test_num != cur.test_num) begin
        close_test(cur.test_num);
      end
      @(posedge clk);
    end

    $display("summary: %0d tests ok, %0d tests with errors, %0d mismatches",
             tests_ok, tests_bad, error_count);
    if (error_count == 0 && tests_bad == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog on the number of clock cycles
  initial begin
    cycle_count = 0;
    @(posedge clk);
    cycle_count = 1;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run timed out after %0d cycles without finishing", cycle_count);
    $display("test failed");
    $finish;
  end

endmodule

/* sm83_control_golden.txt */
// Columns: test _ rst _ opcode in _ expected addr_ctrl (16 bits) _ expected data_ctrl
// data_ctrl is 25 bits shown as 7 hex digits, top 3 bits zero; one line per clock cycle
// 1: single-cycle group, HALT stands for an unlisted opcode
01_0_76_6cc0_0738000
01_0_41_6cc0_1184040
01_0_83_6cc0_13bc1a0
01_0_bd_6cc0_153cfa0
01_0_14_6cc0_1294022
01_0_25_6cc0_14a4422
01_0_07_6cc0_17be020
01_0_37_6cc0_073ec20
// 2: LD BC,d16 and LD SP,d16, immediates on the opcode input are ignored
02_0_01_acc0_07c0000
02_0_34_acc0_07c8000
02_0_12_6cc8_0738000
02_0_31_acc0_07c0000
02_0_fe_acc0_07c8000
02_0_ff_6ccb_0738000
02_0_41_6cc0_1184040
// 3: LD A,[DE] then LD [HL-],A
03_0_1a_8940_07c0000
03_0_00_6cc0_18bc040
03_0_32_faa0_1738001
03_0_00_6cc0_0738000
// 4: LD C,[HL], LD [HL],E, XOR A,[HL], LD [HL],d8
04_0_4e_8a40_07c0000
04_0_00_6cc0_188c040
04_0_73_ca40_1338001
04_0_00_6cc0_0738000
04_0_ae_8a40_07c0000
04_0_00_6cc0_18bcba0
04_0_36_acc0_07c0000
04_0_5a_ca40_183c040
04_0_00_6cc0_0738000
// 5: INC [HL] then DEC BC
05_0_34_8a40_07c0000
05_0_00_ca40_1844022
05_0_00_6cc0_0738000
05_0_0b_3880_0738000
05_0_00_6cc0_0738000
// 6: CB as NOP, reset in cycle 1 of LD [HL],d8, then LD A,[DE] from cycle 0
06_0_cb_6cc0_0738000
06_0_36_acc0_07c0000
06_1_5a_ca40_183c040
06_0_1a_8940_07c0000
06_0_00_6cc0_18bc040

/* build.f */
sm83_ctrl_pkg.sv
insn_sequencer.sv
insn_decoder.sv
addr_step_gen.sv
data_step_gen.sv
sm83_control.sv
tb_sm83_control.sv

/* Makefile */
TOP = tb_sm83_control

.PHONY: all lint clean

all:
	verilator --binary --top-module $(TOP) -f build.f
	out="$$(obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir
